/* source/cache_pkg.sv */
// Fixed geometry of 16 lines of 4 words, 32-bit byte addresses; changing one width means re-deriving the others by hand.

package cache_pkg;

        // ----------------------------
        // Widths.
        // ----------------------------
        localparam int ADDR_W         = 32;     // Byte address.
        localparam int DATA_W         = 32;     // One data word.

        // ----------------------------
        // Cache geometry.
        // ----------------------------
        localparam int WORDS_PER_LINE = 4;      // Words per line.
        localparam int NUM_LINES      = 16;     // 256 bytes in all.
        localparam int INDEX_W        = 4;      // Line index.
        localparam int TAG_W          = 24;     // Bits above index and offset.

        // ----------------------------
        // Types.
        // ----------------------------
        typedef logic [ADDR_W-1:0]     t_addr;     // Byte address.
        typedef logic [DATA_W-1:0]     t_word;     // Data word.
        typedef logic [DATA_W/8-1:0]   t_ben;      // One enable per byte.
        typedef logic [TAG_W-1:0]      t_tag;      // Stored tag.
        typedef logic [INDEX_W-1:0]    t_index;    // Line index.
        typedef logic [1:0]            t_word_sel; // Word within a line.

        // Word 0 sits in the low 32 bits.
        typedef logic [WORDS_PER_LINE-1:0][DATA_W-1:0] t_line;

        // Controller states.
        typedef enum logic [1:0]
        {
                IDLE    = 2'd0, // Decide hit, write, bypass or miss.
                FILL    = 2'd1, // Linefill reads in flight.
                INSTALL = 2'd2  // Write tag and line.
        } t_cache_state;

endpackage

/* source/cache_array.sv */
// Read is combinational from i_index; one index serves read and write, so only one access at a time.

`timescale 1ns/1ps

module cache_array
        import cache_pkg::*;
#(
        parameter type t_entry = t_tag      // Payload stored per line.
)
(
        input  logic   i_clk,               // Clock.
        input  logic   i_reset,             // Clears all valid bits.
        input  logic   i_inv,               // Bulk invalidate pulse.
        input  logic   i_wen,               // Write strobe.
        input  t_index i_index,             // Line to read or write.
        input  t_entry i_wdata,             // New payload.
        output t_entry o_rdata,             // Payload at i_index.
        output logic   o_valid              // Valid bit at i_index.
);

        // ----------------------------
        // Storage.
        // ----------------------------
        t_entry               mem [NUM_LINES]; // Payload, no reset.
        logic [NUM_LINES-1:0] valid_q;         // One bit per line.

        // Payload write.
        always_ff @(posedge i_clk)
        begin
                if (i_wen)
                        mem[i_index] <= i_wdata;
        end

        // Valid bits. Invalidate wins over a write.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_inv)
                begin
                        valid_q <= '0;
                end
                else if (i_wen)
                begin
                        valid_q[i_index] <= 1'b1; // Line now holds data.
                end
        end

        // ----------------------------
        // Read side.
        // ----------------------------
        assign o_rdata = mem[i_index];     // Combinational read.
        assign o_valid = valid_q[i_index];

        // Invalidate comes from the core, writes from the controller.
        // The two must never collide or a fresh line could survive a flush.
        a_no_inv_during_write : assert property (@(posedge i_clk) disable iff (i_reset)
                !(i_inv && i_wen));

endmodule

/* source/fill_counter.sv */
// Two-bit beat counter; assumes WORDS_PER_LINE is 4 so that wrapping lands back on zero.

`timescale 1ns/1ps

module fill_counter
        import cache_pkg::*;
(
        input  logic      i_clk,       // Clock.
        input  logic      i_reset,     // Sync reset.
        input  logic      i_clear,     // Restart at word 0.
        input  logic      i_advance,   // One beat done.
        output t_word_sel o_word_sel,  // Current beat.
        output logic      o_last       // Final beat of the line.
);

        t_word_sel count_q;              // Beat number.

        // ----------------------------
        // Counter.
        // ----------------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                begin
                        count_q <= '0;
                end
                else if (i_advance)
                begin
                        count_q <= count_q + 1'b1; // Wraps after the last word.
                end
        end

        assign o_word_sel = count_q;
        assign o_last     = (count_q == t_word_sel'(WORDS_PER_LINE - 1)); // Beat 3.

        // Clear belongs to IDLE and advance to FILL in the controller.
        a_no_clear_with_advance : assert property (@(posedge i_clk) disable iff (i_reset)
                !(i_advance && i_clear));

endmodule

/* source/line_buffer.sv */
// The last fill word is kept as well, since INSTALL comes a cycle after the final RAM read data.

`timescale 1ns/1ps

module line_buffer
        import cache_pkg::*;
(
        input  logic      i_clk,          // Clock.
        input  logic      i_reset,        // Sync reset.
        input  logic      i_capture,      // Fill word valid.
        input  t_word_sel i_word_sel,     // Fill beat or addressed word.
        input  t_word     i_fill_word,    // Word from RAM.
        input  t_line     i_cached_line,  // Line read from the data array.
        input  t_word     i_wr_data,      // Core write data.
        input  t_ben      i_ben,          // Core byte enables.
        output t_line     o_fill_line,    // Assembled linefill.
        output t_line     o_merged_line,  // Cached line with write bytes.
        output t_word     o_rd_word       // Addressed word for reads.
);

        t_line fill_q;                      // Words gathered so far.

        // ----------------------------
        // Linefill capture.
        // ----------------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        fill_q <= '0;
                end
                else if (i_capture)
                begin
                        fill_q[i_word_sel] <= i_fill_word; // One beat per strobe.
                end
        end

        assign o_fill_line = fill_q;        // Whole line once beat 3 is in.

        // ----------------------------
        // Write merge.
        // ----------------------------
        // Only the addressed word changes; other words pass through.
        always_comb
        begin
                o_merged_line = i_cached_line;
                for (int b = 0; b < DATA_W / 8; b++)
                begin
                        if (i_ben[b])
                                o_merged_line[i_word_sel][8*b +: 8] = i_wr_data[8*b +: 8];
                end
        end

        // Read word select.
        assign o_rd_word = i_cached_line[i_word_sel];

endmodule

/* source/cache_fsm.sv */
// Assumes the core never raises read and write together and holds its request while o_stall is high.

`timescale 1ns/1ps

module cache_fsm
        import cache_pkg::*;
(
        input  logic      i_clk,            // Clock.
        input  logic      i_reset,          // Sync reset.
        input  logic      i_read_en,        // Core read.
        input  logic      i_write_en,       // Core write.
        input  logic      i_cache_en,       // Cache on.
        input  t_addr     i_address,        // Core byte address.
        input  logic      i_hit,            // Tag match and valid.
        input  logic      i_ram_done,       // RAM command finished.
        input  logic      i_last,           // Final fill beat.
        input  t_word_sel i_word_sel,       // Current fill beat.
        output logic      o_stall,          // Hold the core.
        output logic      o_ram_rd_en,      // RAM read command.
        output logic      o_ram_wr_en,      // RAM write command.
        output t_addr     o_ram_address,    // RAM address.
        output logic      o_tag_wen,        // Tag array write.
        output logic      o_data_wen,       // Data array write.
        output logic      o_use_merge,      // Data array takes the merged line.
        output logic      o_capture,        // Store fill word.
        output logic      o_count_clear,    // Reset beat counter.
        output logic      o_count_advance   // Next beat.
);

        t_cache_state state_q, state_d;     // Controller state.
        logic         request;              // Any core access.

        assign request = i_read_en | i_write_en;

        // ------------------------------
        // Next state and outputs.
        // ------------------------------
        always_comb
        begin
                // Defaults. Nothing happens.
                state_d         = state_q;
                o_stall         = 1'b0;
                o_ram_rd_en     = 1'b0;
                o_ram_wr_en     = 1'b0;
                o_ram_address   = i_address;
                o_tag_wen       = 1'b0;
                o_data_wen      = 1'b0;
                o_use_merge     = 1'b0;
                o_capture       = 1'b0;
                o_count_clear   = 1'b0;
                o_count_advance = 1'b0;

                case (state_q)
                IDLE:
                begin
                        if (!i_cache_en)
                        begin
                                // Bypass. Straight to RAM.
                                o_ram_wr_en = i_write_en;
                                o_ram_rd_en = i_read_en;
                                o_stall     = request && !i_ram_done;
                        end
                        else if (i_write_en)
                        begin
                                // Write-through for hits and misses alike.
                                o_ram_wr_en = 1'b1;
                                o_stall     = !i_ram_done;

                                // Hit line updated on the completing edge.
                                if (i_hit && i_ram_done)
                                begin
                                        o_data_wen  = 1'b1;
                                        o_use_merge = 1'b1;
                                end
                        end
                        else if (i_read_en && !i_hit)
                        begin
                                // Miss. Start a linefill at word 0.
                                o_stall       = 1'b1;
                                o_count_clear = 1'b1;
                                state_d       = FILL;
                        end
                        // A read hit completes here with no stall.
                end

                FILL:
                begin
                        o_stall       = 1'b1;
                        o_ram_rd_en   = 1'b1;
                        o_ram_address = {i_address[ADDR_W-1:4], i_word_sel, 2'b00}; // Line base.

                        if (i_ram_done)
                        begin
                                o_capture       = 1'b1;
                                o_count_advance = 1'b1;
                                if (i_last)
                                        state_d = INSTALL; // Four words in.
                        end
                end

                INSTALL:
                begin
                        o_stall    = 1'b1;  // Read is served next cycle as a hit.
                        o_tag_wen  = 1'b1;
                        o_data_wen = 1'b1;  // Fill line with merge select low.
                        state_d    = IDLE;
                end

                default:
                begin
                        state_d = IDLE;     // Unused encoding.
                end
                endcase
        end

        // ------------------------------
        // State register.
        // ------------------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        state_q <= IDLE;
                else
                        state_q <= state_d;
        end

        // Bypass, write-through and fill all share the RAM port.
        a_one_ram_cmd : assert property (@(posedge i_clk) disable iff (i_reset)
                !(o_ram_rd_en && o_ram_wr_en));

endmodule

/* source/dcache_top.sv */
// Direct-mapped write-through cache, no MMU; write misses do not allocate and one access is in flight.

`timescale 1ns/1ps

module dcache_top
        import cache_pkg::*;
(
        input  logic  i_clk,          // Clock.
        input  logic  i_reset,        // Sync reset.

        // Core side.
        input  logic  i_read_en,      // Read request.
        input  logic  i_write_en,     // Write request.
        input  t_addr i_address,      // Byte address.
        input  t_word i_wr_data,      // Write data.
        input  t_ben  i_ben,          // Byte enables.
        output t_word o_rd_data,      // Valid when request and no stall.
        output logic  o_stall,        // Hold request.

        // Configuration.
        input  logic  i_cache_en,     // Level.
        input  logic  i_cache_inv,    // One-cycle pulse.

        // RAM side.
        output t_addr o_ram_address,  // RAM address.
        output t_word o_ram_wr_data,  // RAM write data.
        output t_ben  o_ram_ben,      // RAM byte enables.
        output logic  o_ram_rd_en,    // Read command.
        output logic  o_ram_wr_en,    // Write command.
        input  t_word i_ram_rd_data,  // Valid with done.
        input  logic  i_ram_done      // Command finished.
);

        // ----------------------------
        // Nets.
        // ----------------------------
        t_index    index;                   // Line index from address.
        t_tag      addr_tag;                // Tag part of address.
        t_tag      tag_rdata;               // Stored tag.
        logic      tag_valid, data_valid;   // Valid bits.
        t_line     line_rdata;              // Stored line.
        t_line     fill_line, merged_line;  // Line buffer outputs.
        t_line     data_wdata;              // Data array write data.
        t_word     rd_word;                 // Addressed cached word.
        logic      hit;
        logic      tag_wen, data_wen, use_merge;
        logic      capture, count_clear, count_advance;
        logic      last;
        t_word_sel count_sel;               // Fill beat.

        assign index    = i_address[ADDR_W-TAG_W-1 -: INDEX_W]; // Bits 7:4.
        assign addr_tag = i_address[ADDR_W-1 -: TAG_W];         // Bits 31:8.

        assign hit = tag_valid && data_valid && (tag_rdata == addr_tag);

        assign data_wdata = use_merge ? merged_line : fill_line;

        // ----------------------------
        // Controller.
        // ----------------------------
        cache_fsm u_fsm (
                .i_clk           (i_clk),
                .i_reset         (i_reset),
                .i_read_en       (i_read_en),
                .i_write_en      (i_write_en),
                .i_cache_en      (i_cache_en),
                .i_address       (i_address),
                .i_hit           (hit),
                .i_ram_done      (i_ram_done),
                .i_last          (last),
                .i_word_sel      (count_sel),
                .o_stall         (o_stall),
                .o_ram_rd_en     (o_ram_rd_en),
                .o_ram_wr_en     (o_ram_wr_en),
                .o_ram_address   (o_ram_address),
                .o_tag_wen       (tag_wen),
                .o_data_wen      (data_wen),
                .o_use_merge     (use_merge),
                .o_capture       (capture),
                .o_count_clear   (count_clear),
                .o_count_advance (count_advance)
        );

        fill_counter u_counter (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_clear    (count_clear),
                .i_advance  (count_advance),
                .o_word_sel (count_sel),
                .o_last     (last)
        );

        // ----------------------------
        // Arrays.
        // ----------------------------
        cache_array #(.t_entry(t_tag)) u_tag_array (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .i_inv   (i_cache_inv),
                .i_wen   (tag_wen),
                .i_index (index),
                .i_wdata (addr_tag),
                .o_rdata (tag_rdata),
                .o_valid (tag_valid)
        );

        cache_array #(.t_entry(t_line)) u_data_array (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .i_inv   (i_cache_inv),
                .i_wen   (data_wen),
                .i_index (index),
                .i_wdata (data_wdata),
                .o_rdata (line_rdata),
                .o_valid (data_valid)
        );

        // Word select follows the RAM address: fill beat in FILL, core word otherwise.
        line_buffer u_line_buffer (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_capture     (capture),
                .i_word_sel    (o_ram_address[3:2]),
                .i_fill_word   (i_ram_rd_data),
                .i_cached_line (line_rdata),
                .i_wr_data     (i_wr_data),
                .i_ben         (i_ben),
                .o_fill_line   (fill_line),
                .o_merged_line (merged_line),
                .o_rd_word     (rd_word)
        );

        // ----------------------------
        // Outputs.
        // ----------------------------
        assign o_rd_data     = (i_cache_en && hit) ? rd_word : i_ram_rd_data; // Hit or RAM.
        assign o_ram_wr_data = i_wr_data;   // Write-through.
        assign o_ram_ben     = i_ben;

endmodule

/* sim/tb_dcache_tests.svh */
// Directed tests run in order; later tests rely on lines installed by earlier ones.

// ------------------------------
// Linefill and hit.
// ------------------------------
task automatic read_miss_then_hit();
        t_addr base;
        t_word exp;
        t_word got;
        int    i;

        $display("Test 1: read miss then hit");
        base = 32'h0000_1230;                   // Index 3.
        exp  = model_word(32'h0000_1234);
        clear_traffic();
        read_word(32'h0000_1234, got);
        check_word("miss read data", got, exp);
        check_count("linefill reads", rd_count, 4);
        for (i = 0; i < 4; i++)
                check_addr("linefill order", rd_log[i], base + t_addr'(4 * i)); // Ascending.

        exp = model_word(32'h0000_123C);        // Other word of the same line.
        clear_traffic();
        read_word(32'h0000_123C, got);
        check_word("hit read data", got, exp);
        check_count("hit RAM reads", rd_count, 0);
endtask

task automatic write_hit_merge();
        t_addr addr;
        t_word exp;
        t_word got;

        $display("Test 2: write-through hit");
        addr = 32'h0000_1238;
        exp  = merge_bytes(model_word(addr), 32'hDEAD_BEEF, 4'b0101);
        clear_traffic();
        write_word(addr, 32'hDEAD_BEEF, 4'b0101);
        check_count("write hit RAM writes", wr_count, 1);
        check_count("write hit RAM reads", rd_count, 0);
        check_addr("write hit address", wr_log[0], addr);
        check_word("RAM after write hit", model_word(addr), exp);
        clear_traffic();
        read_word(addr, got);                   // Merged line in cache.
        check_word("read after write hit", got, exp);
        check_count("read after write hit RAM reads", rd_count, 0);
endtask

// ------------------------------
// No allocation, eviction.
// ------------------------------
task automatic write_miss_no_alloc();
        t_addr addr;
        t_word exp;
        t_word got;

        $display("Test 3: write miss does not allocate");
        addr = 32'h0000_2058;                   // Index 5, word 2.
        exp  = merge_bytes(model_word(addr), 32'h1122_3344, 4'b1100);
        clear_traffic();
        write_word(addr, 32'h1122_3344, 4'b1100);
        check_count("write miss RAM writes", wr_count, 1);
        check_count("write miss RAM reads", rd_count, 0);
        clear_traffic();
        read_word(addr, got);
        check_word("read after write miss", got, exp);
        check_count("fill after write miss", rd_count, 4);
        check_addr("fill start", rd_log[0], 32'h0000_2050);
endtask

task automatic conflict_eviction();
        t_addr addr;
        t_word exp;
        t_word got;
        int    i;

        $display("Test 4: conflict eviction");
        for (i = 0; i < 6; i++)
        begin
                addr = (i % 2 == 0) ? 32'h0000_3464 : 32'h0000_7464; // Both index 6.
                exp  = model_word(addr);
                clear_traffic();
                read_word(addr, got);
                check_word("conflict read data", got, exp);
                check_count("conflict refill reads", rd_count, 4);
        end
endtask

// ------------------------------
// Invalidate and bypass.
// ------------------------------
task automatic invalidate_refill();
        t_word got;

        $display("Test 5: invalidate");
        clear_traffic();
        read_word(32'h0000_2054, got);          // Line from test 3.
        check_word("cached read data", got, model_word(32'h0000_2054));
        check_count("cached before invalidate", rd_count, 0);
        @(negedge i_clk);
        i_cache_inv = 1'b1;
        @(negedge i_clk);
        i_cache_inv = 1'b0;
        clear_traffic();
        read_word(32'h0000_2054, got);
        check_word("read after invalidate", got, model_word(32'h0000_2054));
        check_count("refill after invalidate", rd_count, 4);
endtask

task automatic cache_disabled_bypass();
        t_word exp;
        t_word got;

        $display("Test 6: cache disabled");
        @(negedge i_clk);
        i_cache_en = 1'b0;
        exp = model_word(32'h0000_2054);
        clear_traffic();
        read_word(32'h0000_2054, got);          // Cached line still bypassed.
        check_word("bypass read data", got, exp);
        check_count("bypass RAM reads", rd_count, 1);
        check_count("bypass read RAM writes", wr_count, 0);
        check_addr("bypass read address", rd_log[0], 32'h0000_2054);

        exp = merge_bytes(model_word(32'h0000_4448), 32'hCAFE_F00D, 4'b0011);
        clear_traffic();
        write_word(32'h0000_4448, 32'hCAFE_F00D, 4'b0011);
        check_count("bypass RAM writes", wr_count, 1);
        check_count("bypass write RAM reads", rd_count, 0);
        check_addr("bypass write address", wr_log[0], 32'h0000_4448);
        check_word("RAM after bypass write", model_word(32'h0000_4448), exp);
        clear_traffic();
        read_word(32'h0000_4448, got);
        check_word("bypass read back", got, exp);
        check_count("bypass read back RAM reads", rd_count, 1);
        @(negedge i_clk);
        i_cache_en = 1'b1;
endtask

/* sim/tb_dcache.sv */
// Directed testbench for dcache_top; the RAM model answers in 1 to 3 cycles and needs a timing-aware simulator.

`timescale 1ns/1ps

module tb_dcache
        import cache_pkg::*;
();

        localparam int CLK_PERIOD   = 100;  // ns.
        localparam int NUM_TESTS    = 6;
        localparam int MAX_ACCESSES = 40;   // Upper bound per test.
        localparam int MAX_CYCLES   = 20;   // Upper bound per access.

        // ------------------------------
        // DUT signals.
        // ------------------------------
        logic  i_clk, i_reset;
        logic  i_read_en, i_write_en;       // Core request.
        t_addr i_address;
        t_word i_wr_data;
        t_ben  i_ben;
        t_word o_rd_data;
        logic  o_stall;
        logic  i_cache_en, i_cache_inv;     // Configuration.
        t_addr o_ram_address;
        t_word o_ram_wr_data;
        t_ben  o_ram_ben;
        logic  o_ram_rd_en, o_ram_wr_en;
        t_word i_ram_rd_data;
        logic  i_ram_done;

        // RAM model state and traffic counters.
        t_word  ram_mem [t_addr];           // Keyed by word-aligned address.
        int     rd_count, wr_count;
        t_addr  rd_log [$];                 // Read addresses in order.
        t_addr  wr_log [$];
        integer seed = 73;                  // Latency randomization.
        int     error_count;

        dcache_top UUT (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_read_en     (i_read_en),
                .i_write_en    (i_write_en),
                .i_address     (i_address),
                .i_wr_data     (i_wr_data),
                .i_ben         (i_ben),
                .o_rd_data     (o_rd_data),
                .o_stall       (o_stall),
                .i_cache_en    (i_cache_en),
                .i_cache_inv   (i_cache_inv),
                .o_ram_address (o_ram_address),
                .o_ram_wr_data (o_ram_wr_data),
                .o_ram_ben     (o_ram_ben),
                .o_ram_rd_en   (o_ram_rd_en),
                .o_ram_wr_en   (o_ram_wr_en),
                .i_ram_rd_data (i_ram_rd_data),
                .i_ram_done    (i_ram_done)
        );

        // Clock.
        initial
        begin
                i_clk = 1'b0;
                forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
        end

        // ------------------------------
        // Reference helpers.
        // ------------------------------
        // Unwritten RAM holds a pattern of the whole address.
        function automatic t_word fill_pattern(input t_addr addr);
                return {addr[15:0], addr[31:16]} ^ 32'h3C5A_96E1;
        endfunction

        function automatic t_word model_word(input t_addr addr);
                t_addr key;
                key = {addr[ADDR_W-1:2], 2'b00};    // Word aligned.
                if (ram_mem.exists(key))
                        return ram_mem[key];
                return fill_pattern(key);
        endfunction

        // Bytes with their enable set come from the new word.
        function automatic t_word merge_bytes(input t_word old_word, input t_word new_word,
                                              input t_ben ben);
                t_word mask;
                mask = {{8{ben[3]}}, {8{ben[2]}}, {8{ben[1]}}, {8{ben[0]}}};
                return (old_word & ~mask) | (new_word & mask);
        endfunction

        // ------------------------------
        // Compare tasks.
        // ------------------------------
        task automatic report_error(input string msg);
                error_count++;
                $display("FAILED at time %0t: %s", $time, msg);
                $display("Done: errors found");
                $fatal(1, "stopped at first error");
        endtask

        task automatic check_word(input string what, input t_word got, input t_word exp);
                if (got !== exp)
                        report_error($sformatf("%s: got %h, expected %h", what, got, exp));
        endtask

        task automatic check_addr(input string what, input t_addr got, input t_addr exp);
                if (got !== exp)
                        report_error($sformatf("%s: got %h, expected %h", what, got, exp));
        endtask

        task automatic check_count(input string what, input int got, input int exp);
                if (got != exp)
                        report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
        endtask

        // ------------------------------
        // Core-side driver.
        // ------------------------------
        task automatic clear_traffic();
                rd_count = 0;
                wr_count = 0;
                rd_log.delete();
                wr_log.delete();
        endtask

        // Holds the request until a cycle ends with o_stall low.
        task automatic access(input logic is_write, input t_addr addr, input t_word wdata,
                              input t_ben ben, output t_word rdata);
                @(negedge i_clk);
                i_address  = addr;
                i_wr_data  = wdata;
                i_ben      = ben;
                i_write_en = is_write;
                i_read_en  = !is_write;
                @(posedge i_clk);
                while (o_stall)
                        @(posedge i_clk);
                rdata = o_rd_data;                  // Valid in the completing cycle.
                @(negedge i_clk);
                i_read_en  = 1'b0;
                i_write_en = 1'b0;
        endtask

        task automatic read_word(input t_addr addr, output t_word rdata);
                access(1'b0, addr, '0, '0, rdata);
        endtask

        task automatic write_word(input t_addr addr, input t_word wdata, input t_ben ben);
                t_word unused;
                access(1'b1, addr, wdata, ben, unused);
        endtask

        // ------------------------------
        // RAM model.
        // ------------------------------
        initial
        begin : ram_model
                t_addr cmd_addr;
                t_word cmd_data;
                t_ben  cmd_ben;
                logic  cmd_write;
                int    delay;

                i_ram_done    = 1'b0;
                i_ram_rd_data = '0;
                forever
                begin
                        @(posedge i_clk);                       // Command seen before the edge.
                        if (!i_reset && (o_ram_rd_en || o_ram_wr_en))
                        begin
                                cmd_addr  = o_ram_address;
                                cmd_data  = o_ram_wr_data;
                                cmd_ben   = o_ram_ben;
                                cmd_write = o_ram_wr_en;
                                delay     = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
                                repeat (delay - 1) @(posedge i_clk);
                                @(negedge i_clk);
                                if (cmd_write)
                                begin
                                        ram_mem[{cmd_addr[ADDR_W-1:2], 2'b00}] =
                                                merge_bytes(model_word(cmd_addr), cmd_data, cmd_ben);
                                        wr_count++;
                                        wr_log.push_back(cmd_addr);
                                end
                                else
                                begin
                                        i_ram_rd_data = model_word(cmd_addr);
                                        rd_count++;
                                        rd_log.push_back(cmd_addr);
                                end
                                i_ram_done = 1'b1;              // One-cycle pulse.
                                @(negedge i_clk);
                                i_ram_done = 1'b0;
                        end
                end
        end

        `include "tb_dcache_tests.svh"

        // Watchdog sized from the longest possible run.
        initial
        begin : watchdog
                #(NUM_TESTS * MAX_ACCESSES * MAX_CYCLES * CLK_PERIOD);
                $display("Watchdog: the run timed out before all tests finished.");
                $display("Done: errors found");
                $fatal(1, "watchdog timeout");
        end

        // ------------------------------
        // Main sequence.
        // ------------------------------
        initial
        begin
                error_count = 0;
                i_reset     = 1'b1;
                i_read_en   = 1'b0;
                i_write_en  = 1'b0;
                i_address   = '0;
                i_wr_data   = '0;
                i_ben       = '0;
                i_cache_en  = 1'b1;
                i_cache_inv = 1'b0;
                clear_traffic();
                repeat (3) @(negedge i_clk);        // Three reset cycles.
                i_reset = 1'b0;

                read_miss_then_hit();
                write_hit_merge();
                write_miss_no_alloc();
                conflict_eviction();
                invalidate_refill();
                cache_disabled_bypass();

                if (error_count == 0)
                        $display("Done: no errors");
                else
                        $display("Done: errors found");
                $finish;
        end

endmodule

/* files.f */
+incdir+sim
source/cache_pkg.sv
source/cache_array.sv
source/fill_counter.sv
source/line_buffer.sv
source/cache_fsm.sv
source/dcache_top.sv
sim/tb_dcache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the cache testbench with Verilator; exit status follows the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
        --timescale 1ns/1ps \
        -f files.f \
        --top-module tb_dcache \
        -Mdir obj_dir -o sim_dcache

# The simulator exits non-zero on a failed check, so the log decides.
./obj_dir/sim_dcache > sim.log 2>&1 || true
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
        echo "Simulation passed."
        exit 0
else
        echo "Simulation failed, see sim.log."
        exit 1
fi
